//--- Makefile
# Verilator build for the replica random block.

VERILATOR ?= verilator
TOP       ?= replica_rand_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/or_rand.sv
`timescale 1ns/1ns
module or_rand (
    input  logic clk,
    input  logic arst_n,
    rand_if.gen  g
);
    import replica_pkg::*;

    logic run_q;
    opt_t opt_q;
    opt_t opt_d;

    assign g.n_seed = xorshift64(g.seed);
    assign g.run_o  = run_q;
    assign g.ready  = ~(g.run_i | run_q);   // busy from request to write back.
    assign g.opt    = opt_q;

    always_comb begin
        opt_d                              = '0;
        opt_d.flip.spin_idx[spin_log-1:0]  = g.n_seed[spin_log-1:0];
        opt_d.flip.accept                  = g.n_seed[seed_w-1 -: 16];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_q <= 1'b0;
            opt_q <= '0;
        end else begin
            run_q <= g.run_i;
            if (run_q && g.opt_en) begin
                opt_q <= opt_d;   // hold when disabled.
            end
        end
    end

endmodule

//--- hdl/rand_apb_regs.sv
`timescale 1ns/1ns
module rand_apb_regs (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [replica_pkg::apb_addr_w-1:0]   paddr,
    input  logic [replica_pkg::apb_data_w-1:0]   pwdata,
    output logic [replica_pkg::apb_data_w-1:0]   prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    input  logic                                 ready,
    input  replica_pkg::opt_t                    or_opt,
    input  replica_pkg::opt_t                    tw_opt,
    output logic                                 run,
    output logic                                 init,
    output logic                                 or_opt_en,
    output logic                                 tw_opt_en,
    output logic [replica_pkg::base_log-1:0]     or_base_id,
    output logic [replica_pkg::base_log-1:0]     tw_base_id,
    output logic [replica_pkg::seed_w-1:0]       i_seed
);
    import replica_pkg::*;

    logic                  access;
    logic                  wr_en;
    logic                  hit;
    logic [apb_data_w-1:0] seed_lo_q;
    logic [apb_data_w-1:0] seed_hi_q;
    opt_t                  or_opt_q;
    opt_t                  tw_opt_q;

    assign access  = psel & penable;
    assign wr_en   = access & pwrite;
    assign pready  = 1'b1;              // zero wait states.
    assign pslverr = access & ~hit;
    assign i_seed  = {seed_hi_q, seed_lo_q};

    always_comb begin
        hit    = 1'b1;
        prdata = '0;
        case (paddr)
            addr_ctrl: begin
                prdata[ctrl_or_en] = or_opt_en;
                prdata[ctrl_tw_en] = tw_opt_en;
            end
            addr_base: begin
                prdata[base_or_lsb +: base_log] = or_base_id;
                prdata[base_tw_lsb +: base_log] = tw_base_id;
            end
            addr_seed_lo: prdata = seed_lo_q;
            addr_seed_hi: prdata = seed_hi_q;
            addr_status:  prdata[status_ready] = ready;
            addr_or_opt:  prdata = or_opt_q;
            addr_tw_opt:  prdata = tw_opt_q;
            default:      hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run        <= 1'b0;
            init       <= 1'b0;
            or_opt_en  <= 1'b0;
            tw_opt_en  <= 1'b0;
            or_base_id <= '0;
            tw_base_id <= '0;
            seed_lo_q  <= '0;
            seed_hi_q  <= '0;
            or_opt_q   <= '0;
            tw_opt_q   <= '0;
        end else begin
            run      <= 1'b0;
            init     <= 1'b0;
            or_opt_q <= or_opt;
            tw_opt_q <= tw_opt;
            if (wr_en) begin
                case (paddr)
                    addr_ctrl: begin
                        or_opt_en <= pwdata[ctrl_or_en];
                        tw_opt_en <= pwdata[ctrl_tw_en];
                        init      <= pwdata[ctrl_init];
                        run       <= pwdata[ctrl_run] & ready;   // dropped while busy.
                    end
                    addr_base: begin
                        or_base_id <= pwdata[base_or_lsb +: base_log];
                        tw_base_id <= pwdata[base_tw_lsb +: base_log];
                    end
                    addr_seed_lo: seed_lo_q <= pwdata;
                    addr_seed_hi: seed_hi_q <= pwdata;
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- hdl/rand_if.sv
`timescale 1ns/1ns
interface rand_if;
    import replica_pkg::*;

    logic [base_log-1:0] base_id;
    logic [seed_w-1:0]   seed;     // current seed of the selected base.
    logic [seed_w-1:0]   n_seed;   // seed after one step.
    logic                run_i;
    logic                run_o;
    logic                opt_en;
    opt_t                opt;
    logic                ready;

    modport bank (
        output base_id, seed, run_i, opt_en,
        input  n_seed, run_o, opt, ready
    );

    modport gen (
        input  base_id, seed, run_i, opt_en,
        output n_seed, run_o, opt, ready
    );

endinterface

//--- hdl/random.sv
`timescale 1ns/1ns
module random (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               run,
    input  logic                               init,
    input  logic [replica_pkg::base_log-1:0]   or_base_id,
    input  logic [replica_pkg::base_log-1:0]   tw_base_id,
    input  logic                               or_opt_en,
    input  logic                               tw_opt_en,
    input  logic [replica_pkg::seed_w-1:0]     i_seed,
    output replica_pkg::opt_t                  or_opt,
    output replica_pkg::opt_t                  tw_opt,
    output logic                               ready
);
    import replica_pkg::*;

    logic [seed_w-1:0] bank [base_num];

    rand_if or_g ();
    rand_if tw_g ();

    assign or_g.base_id = or_base_id;
    assign or_g.seed    = bank[or_g.base_id];
    assign or_g.run_i   = run;
    assign or_g.opt_en  = or_opt_en;

    assign tw_g.base_id = tw_base_id;
    assign tw_g.seed    = bank[tw_g.base_id];
    assign tw_g.run_i   = run;
    assign tw_g.opt_en  = tw_opt_en;

    // loaded over APB before the first draw.
    always_ff @(posedge clk) begin
        if (init) begin
            bank[or_g.base_id] <= i_seed;
        end else if (or_g.run_o) begin
            bank[or_g.base_id] <= or_g.n_seed;
        end
        if (tw_g.run_o) begin
            bank[tw_g.base_id] <= tw_g.n_seed;   // wins on a shared base.
        end
    end

    assign or_opt = or_g.opt;
    assign tw_opt = tw_g.opt;
    assign ready  = or_g.ready & tw_g.ready;

    or_rand or_rand_i (
        .clk    (clk),
        .arst_n (arst_n),
        .g      (or_g.gen)
    );

    tw_rand tw_rand_i (
        .clk    (clk),
        .arst_n (arst_n),
        .g      (tw_g.gen)
    );

endmodule

//--- hdl/replica_pkg.sv
package replica_pkg;

    localparam int base_num = 8;
    localparam int base_log = 3;
    localparam int spin_log = 10;
    localparam int seed_w   = 64;

    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;

    localparam logic [apb_addr_w-1:0] addr_ctrl    = 8'h00;
    localparam logic [apb_addr_w-1:0] addr_base    = 8'h04;
    localparam logic [apb_addr_w-1:0] addr_seed_lo = 8'h08;
    localparam logic [apb_addr_w-1:0] addr_seed_hi = 8'h0C;
    localparam logic [apb_addr_w-1:0] addr_status  = 8'h10;
    localparam logic [apb_addr_w-1:0] addr_or_opt  = 8'h14;
    localparam logic [apb_addr_w-1:0] addr_tw_opt  = 8'h18;

    localparam int ctrl_init    = 0;
    localparam int ctrl_run     = 1;
    localparam int ctrl_or_en   = 2;
    localparam int ctrl_tw_en   = 3;
    localparam int base_or_lsb  = 0;
    localparam int base_tw_lsb  = 8;
    localparam int status_ready = 0;

    // proposal word seen as a spin flip or as a replica swap.
    typedef union packed {
        struct packed {
            logic [15:0] spin_idx;
            logic [15:0] accept;
        } flip;
        struct packed {
            logic [7:0]  rep_a;
            logic [7:0]  rep_b;
            logic [15:0] accept;
        } swap;
    } opt_t;

    function automatic logic [seed_w-1:0] xorshift64(input logic [seed_w-1:0] s);
        logic [seed_w-1:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

endpackage

//--- hdl/replica_rand_top.sv
`timescale 1ns/1ns
module replica_rand_top (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [replica_pkg::apb_addr_w-1:0]   paddr,
    input  logic [replica_pkg::apb_data_w-1:0]   pwdata,
    output logic [replica_pkg::apb_data_w-1:0]   prdata,
    output logic                                 pready,
    output logic                                 pslverr
);
    import replica_pkg::*;

    logic                run;
    logic                init;
    logic                ready;
    logic                or_opt_en;
    logic                tw_opt_en;
    logic [base_log-1:0] or_base_id;
    logic [base_log-1:0] tw_base_id;
    logic [seed_w-1:0]   i_seed;
    opt_t                or_opt;
    opt_t                tw_opt;

    rand_apb_regs rand_apb_regs_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .ready      (ready),
        .or_opt     (or_opt),
        .tw_opt     (tw_opt),
        .run        (run),
        .init       (init),
        .or_opt_en  (or_opt_en),
        .tw_opt_en  (tw_opt_en),
        .or_base_id (or_base_id),
        .tw_base_id (tw_base_id),
        .i_seed     (i_seed)
    );

    random random_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .init       (init),
        .or_base_id (or_base_id),
        .tw_base_id (tw_base_id),
        .or_opt_en  (or_opt_en),
        .tw_opt_en  (tw_opt_en),
        .i_seed     (i_seed),
        .or_opt     (or_opt),
        .tw_opt     (tw_opt),
        .ready      (ready)
    );

endmodule

//--- hdl/tw_rand.sv
`timescale 1ns/1ns
module tw_rand (
    input  logic clk,
    input  logic arst_n,
    rand_if.gen  g
);
    import replica_pkg::*;

    logic                run_q;
    logic [base_log-1:0] rep_a;
    logic [base_log-1:0] rep_b;
    opt_t                opt_q;
    opt_t                opt_d;

    assign g.n_seed = xorshift64(g.seed);
    assign g.run_o  = run_q;
    assign g.ready  = ~(g.run_i | run_q);
    assign g.opt    = opt_q;

    // partner is the next replica and wraps at the last one.
    assign rep_a = g.n_seed[base_log-1:0];
    assign rep_b = rep_a + 1'b1;

    always_comb begin
        opt_d                             = '0;
        opt_d.swap.rep_a[base_log-1:0]    = rep_a;
        opt_d.swap.rep_b[base_log-1:0]    = rep_b;
        opt_d.swap.accept                 = g.n_seed[seed_w-1 -: 16];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_q <= 1'b0;
            opt_q <= '0;
        end else begin
            run_q <= g.run_i;
            if (run_q && g.opt_en) begin
                opt_q <= opt_d;
            end
        end
    end

endmodule

//--- project.f
hdl/replica_pkg.sv
hdl/rand_if.sv
hdl/or_rand.sv
hdl/tw_rand.sv
hdl/random.sv
hdl/rand_apb_regs.sv
hdl/replica_rand_top.sv
verification/replica_rand_chk.sv
verification/replica_rand_tb.sv

//--- verification/replica_rand_chk.sv
`timescale 1ns/1ns
module replica_rand_chk (
    input logic clk,
    input logic arst_n,
    input logic run,
    input logic ready,
    input logic or_run_o,
    input logic tw_run_o,
    input logic psel,
    input logic penable,
    input logic pslverr
);

    // each generator delays its request by one flop.
    a_or_pipe: assert property (@(posedge clk) disable iff (!arst_n)
        or_run_o == $past(run))
        else $error("or generator run_o does not follow run_i by one cycle");

    a_tw_pipe: assert property (@(posedge clk) disable iff (!arst_n)
        tw_run_o == $past(run))
        else $error("tw generator run_o does not follow run_i by one cycle");

    a_idle_ready: assert property (@(posedge clk) disable iff (!arst_n)
        (!run && !$past(run)) |-> ready)
        else $error("ready low with no run pending");

    a_slverr: assert property (@(posedge clk) disable iff (!arst_n)
        pslverr |-> (psel && penable && $past(psel) && !$past(penable)))
        else $error("pslverr outside an APB access cycle");

endmodule

bind replica_rand_top replica_rand_chk replica_rand_chk_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .run      (run),
    .ready    (ready),
    .or_run_o (random_i.or_g.run_o),
    .tw_run_o (random_i.tw_g.run_o),
    .psel     (psel),
    .penable  (penable),
    .pslverr  (pslverr)
);

//--- verification/replica_rand_tb.sv
`timescale 1ns/1ns
module replica_rand_tb;
    import replica_pkg::*;

    localparam int n_draws    = 40;
    localparam int n_unmapped = 24;
    localparam int n_txn      = 7 + 4 * base_num + 6 * (n_draws + 6) + n_unmapped + 14;
    localparam int max_cycles = 40 * n_txn + 200;

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [63:0] model [base_num];   // expected seed bank.
    logic [31:0] exp_or   = '0;
    logic [31:0] exp_tw   = '0;
    logic [31:0] exp_ctrl = '0;
    logic [31:0] exp_base = '0;
    logic [31:0] exp_lo   = '0;
    logic [31:0] exp_hi   = '0;
    int          cycles    = 0;

    replica_rand_top replica_rand_top_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("tests failed");
            $fatal(1, "timeout: run did not finish within %0d cycles", max_cycles);
        end
    end

    function automatic logic [63:0] next_seed(input logic [63:0] s);
        logic [63:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    function automatic logic [31:0] flip_word(input logic [63:0] s);
        return {6'b0, s[9:0], s[63:48]};
    endfunction

    function automatic logic [31:0] swap_word(input logic [63:0] s);
        logic [2:0] a;
        logic [2:0] b;
        a = s[2:0];
        b = 3'((32'(a) + 1) % base_num);   // neighbour wraps to replica 0.
        return {5'b0, a, 5'b0, b, s[63:48]};
    endfunction

    function automatic logic [31:0] ctrl_word(input logic init, input logic run,
                                              input logic or_en, input logic tw_en);
        logic [31:0] w;
        w             = '0;
        w[ctrl_init]  = init;
        w[ctrl_run]   = run;
        w[ctrl_or_en] = or_en;
        w[ctrl_tw_en] = tw_en;
        return w;
    endfunction

    function automatic logic [31:0] base_word(input logic [2:0] or_b, input logic [2:0] tw_b);
        return {21'b0, tw_b, 5'b0, or_b};
    endfunction

    function automatic logic is_mapped(input logic [7:0] addr);
        return addr inside {addr_ctrl, addr_base, addr_seed_lo, addr_seed_hi,
                            addr_status, addr_or_opt, addr_tw_opt};
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);   // mid access cycle.
        check("pready", 32'h1, 32'(pready));
        check("pslverr", 32'(exp_err), 32'(pslverr));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            input logic exp_err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check("pready", 32'h1, 32'(pready));
        check("pslverr", 32'(exp_err), 32'(pslverr));
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_ready();
        logic [31:0] rd;
        rd = '0;
        while (rd[0] !== 1'b1) begin
            apb_read(addr_status, rd, 1'b0);
        end
    endtask

    task automatic load_seed(input logic [2:0] b, input logic [63:0] s);
        apb_write(addr_seed_lo, s[31:0], 1'b0);
        apb_write(addr_seed_hi, s[63:32], 1'b0);
        apb_write(addr_base, base_word(b, 3'd0), 1'b0);
        apb_write(addr_ctrl, ctrl_word(1'b1, 1'b0, 1'b1, 1'b1), 1'b0);
        exp_lo   = s[31:0];
        exp_hi   = s[63:32];
        exp_base = base_word(b, 3'd0);
        exp_ctrl = ctrl_word(1'b0, 1'b0, 1'b1, 1'b1);
        model[b] = s;
    endtask

    task automatic draw(input logic [2:0] or_b, input logic [2:0] tw_b,
                        input logic or_en, input logic tw_en);
        logic [63:0] n_or;
        logic [63:0] n_tw;
        logic [31:0] rd;
        apb_write(addr_base, base_word(or_b, tw_b), 1'b0);
        apb_write(addr_ctrl, ctrl_word(1'b0, 1'b1, or_en, tw_en), 1'b0);
        exp_base = base_word(or_b, tw_b);
        exp_ctrl = ctrl_word(1'b0, 1'b0, or_en, tw_en);
        n_or = next_seed(model[or_b]);
        n_tw = next_seed(model[tw_b]);
        model[or_b] = n_or;
        model[tw_b] = n_tw;   // tw write back wins on a shared base.
        if (or_en) begin
            exp_or = flip_word(n_or);
        end
        if (tw_en) begin
            exp_tw = swap_word(n_tw);
        end
        wait_ready();
        apb_read(addr_or_opt, rd, 1'b0);
        check("or_opt", exp_or, rd);
        apb_read(addr_tw_opt, rd, 1'b0);
        check("tw_opt", exp_tw, rd);
    endtask

    task automatic check_regs();
        logic [31:0] rd;
        apb_read(addr_ctrl, rd, 1'b0);
        check("ctrl", exp_ctrl, rd);
        apb_read(addr_base, rd, 1'b0);
        check("base", exp_base, rd);
        apb_read(addr_seed_lo, rd, 1'b0);
        check("seed_lo", exp_lo, rd);
        apb_read(addr_seed_hi, rd, 1'b0);
        check("seed_hi", exp_hi, rd);
        apb_read(addr_or_opt, rd, 1'b0);
        check("or_opt", exp_or, rd);
        apb_read(addr_tw_opt, rd, 1'b0);
        check("tw_opt", exp_tw, rd);
    endtask

    initial begin
        logic [31:0] rd;
        logic [2:0]  ob;
        logic [2:0]  tb_base;
        logic [63:0] cand;
        logic [63:0] nx;
        logic [7:0]  addr;
        logic        found;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        found   = 1'b0;
        cand    = '0;
        void'($urandom(32'h082cea31));
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        apb_read(addr_status, rd, 1'b0);
        check("status.ready", 32'h1, rd);
        check_regs();

        for (int i = 0; i < base_num; i++) begin
            load_seed(3'(i), {$urandom, $urandom});
        end

        for (int i = 0; i < n_draws; i++) begin
            ob      = 3'($urandom);
            tb_base = (i % 5 == 0) ? ob : 3'($urandom);   // some shared bases.
            draw(ob, tb_base, 1'b1, 1'b1);
        end

        // disabled draw still steps both seeds.
        ob      = 3'($urandom);
        tb_base = 3'($urandom);
        draw(ob, tb_base, 1'b0, 1'b0);
        draw(ob, tb_base, 1'b1, 1'b1);
        draw(ob, tb_base, 1'b1, 1'b0);
        draw(ob, tb_base, 1'b0, 1'b1);

        // seed whose next step gives rep_a of 7.
        for (int k = 0; k < 256 && !found; k++) begin
            cand = {$urandom, $urandom};
            nx   = next_seed(cand);
            if (nx[2:0] == 3'd7) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("tests failed");
            $fatal(1, "no seed found that makes rep_a equal 7");
        end
        load_seed(ob, cand);
        draw(ob, ob, 1'b1, 1'b1);

        for (int i = 0; i < n_unmapped; i++) begin
            addr = 8'($urandom);
            while (is_mapped(addr)) begin
                addr = 8'($urandom);
            end
            if ($urandom % 2 == 1) begin
                apb_write(addr, $urandom, 1'b1);
            end else begin
                apb_read(addr, rd, 1'b1);
            end
        end
        check_regs();
        draw(3'($urandom), 3'($urandom), 1'b1, 1'b1);

        $display("all tests passed");
        $finish;
    end

endmodule
